/* hw/exe_ctl_pkg.sv */
`default_nettype none

package exe_ctl_pkg;

    localparam int XLEN = 32;
    localparam int ILEN = 32;

    // RV32I major opcodes, instruction[6:0]
    typedef enum logic [6:0] {
        OPC_LUI      = 7'b0110111,
        OPC_AUIPC    = 7'b0010111,
        OPC_JAL      = 7'b1101111,
        OPC_JALR     = 7'b1100111,
        OPC_BRANCH   = 7'b1100011,
        OPC_LOAD     = 7'b0000011,
        OPC_STORE    = 7'b0100011,
        OPC_OP_IMM   = 7'b0010011,
        OPC_OP       = 7'b0110011,
        OPC_MISC_MEM = 7'b0001111,
        OPC_SYSTEM   = 7'b1110011
    } opcode_e;

    // Encodings as the downstream ALU expects them
    typedef enum logic [3:0] {
        ALU_AND    = 4'b0000,
        ALU_OR     = 4'b0001,
        ALU_XOR    = 4'b0010,
        ALU_ADD    = 4'b0011,
        ALU_SUB    = 4'b0100,
        ALU_PASS_B = 4'b0110,
        ALU_SLL    = 4'b0111,
        ALU_SRL    = 4'b1000,
        ALU_SRA    = 4'b1010,
        ALU_SLTU   = 4'b1011,
        ALU_SLT    = 4'b1100
    } alu_op_e;

    typedef enum logic [3:0] {
        IMM_NONE = 4'd0,
        IMM_I    = 4'd1,
        IMM_S    = 4'd2,
        IMM_B    = 4'd3,
        IMM_U    = 4'd4,
        IMM_J    = 4'd5
    } imm_sel_e;

    // Branch funct3 codes
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // funct7 for the base and alternate (SUB, SRA) forms
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef struct packed {
        logic     a_sel;    // 1 selects PC
        logic     b_sel;    // 1 selects immediate
        imm_sel_e imm_sel;
        alu_op_e  alu_op;
        logic     sign;
    } alu_ctl_t;

    typedef struct packed {
        logic pc_sel;       // 1 takes the ALU target
        logic br_un;
    } br_ctl_t;

    typedef struct packed {
        logic [XLEN-1:0] data_a;
        logic [XLEN-1:0] data_b;
        logic [XLEN-1:0] pc;
        logic [ILEN-1:0] instr;
    } stage_data_t;

    localparam alu_ctl_t ALU_CTL_RESET = '{
        a_sel:   1'b0,
        b_sel:   1'b1,
        imm_sel: IMM_NONE,
        alu_op:  ALU_PASS_B,
        sign:    1'b0
    };

    // Entry for FENCE, ECALL, EBREAK and anything unrecognised
    localparam alu_ctl_t ALU_CTL_NOP = '0;

endpackage

`default_nettype wire

/* hw/alu_ctl_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_ctl_decoder (
    input  logic [exe_ctl_pkg::ILEN-1:0] instruction,
    output exe_ctl_pkg::alu_ctl_t        alu_ctl
);
    import exe_ctl_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       f7_base;
    logic       f7_alt;

    assign opcode  = opcode_e'(instruction[6:0]);
    assign funct3  = instruction[14:12];
    assign f7_base = (instruction[31:25] == F7_BASE);
    assign f7_alt  = (instruction[31:25] == F7_ALT);

    function automatic alu_ctl_t entry(input logic a, input logic b, input imm_sel_e imm,
                                       input alu_op_e op, input logic s);
        alu_ctl_t e;
        e.a_sel   = a;
        e.b_sel   = b;
        e.imm_sel = imm;
        e.alu_op  = op;
        e.sign    = s;
        return e;
    endfunction

    always_comb begin
        alu_ctl = ALU_CTL_NOP;
        case (opcode)
            OPC_LUI:   alu_ctl = entry(1'b0, 1'b1, IMM_U, ALU_PASS_B, 1'b0);
            OPC_AUIPC: alu_ctl = entry(1'b1, 1'b1, IMM_U, ALU_ADD, 1'b0);
            OPC_JAL:   alu_ctl = entry(1'b1, 1'b1, IMM_J, ALU_ADD, 1'b1);
            OPC_JALR:  alu_ctl = entry(1'b0, 1'b1, IMM_I, ALU_ADD, 1'b1);
            OPC_BRANCH: begin
                // funct3 010 and 011 are not branches
                if (funct3 != 3'b010 && funct3 != 3'b011) begin
                    alu_ctl = entry(1'b0, 1'b0, IMM_B, ALU_ADD, 1'b0);
                end
            end
            OPC_LOAD: begin
                case (funct3)
                    3'b000, 3'b001, 3'b010: alu_ctl = entry(1'b0, 1'b1, IMM_I, ALU_ADD, 1'b1);
                    // LBU, LHU zero extend
                    3'b100, 3'b101:         alu_ctl = entry(1'b0, 1'b1, IMM_I, ALU_ADD, 1'b0);
                    default: ;
                endcase
            end
            OPC_STORE: begin
                case (funct3)
                    3'b000, 3'b001, 3'b010: alu_ctl = entry(1'b0, 1'b1, IMM_S, ALU_ADD, 1'b1);
                    default: ;
                endcase
            end
            OPC_OP_IMM: begin
                case (funct3)
                    3'b000: alu_ctl = entry(1'b0, 1'b1, IMM_I, ALU_ADD, 1'b1);
                    3'b010: alu_ctl = entry(1'b0, 1'b1, IMM_I, ALU_SLT, 1'b0);
                    3'b011: alu_ctl = entry(1'b0, 1'b1, IMM_I, ALU_SLTU, 1'b0);
                    3'b100: alu_ctl = entry(1'b0, 1'b1, IMM_I, ALU_XOR, 1'b1);
                    3'b110: alu_ctl = entry(1'b0, 1'b1, IMM_I, ALU_OR, 1'b1);
                    3'b111: alu_ctl = entry(1'b0, 1'b1, IMM_I, ALU_AND, 1'b1);
                    3'b001: begin
                        if (f7_base) alu_ctl = entry(1'b0, 1'b1, IMM_I, ALU_SLL, 1'b0);
                    end
                    default: begin
                        if (f7_base)     alu_ctl = entry(1'b0, 1'b1, IMM_I, ALU_SRL, 1'b0);
                        else if (f7_alt) alu_ctl = entry(1'b0, 1'b1, IMM_I, ALU_SRA, 1'b0);
                    end
                endcase
            end
            OPC_OP: begin
                case (funct3)
                    3'b000: begin
                        if (f7_base)     alu_ctl = entry(1'b0, 1'b0, IMM_NONE, ALU_ADD, 1'b0);
                        else if (f7_alt) alu_ctl = entry(1'b0, 1'b0, IMM_NONE, ALU_SUB, 1'b0);
                    end
                    3'b101: begin
                        if (f7_base)     alu_ctl = entry(1'b0, 1'b0, IMM_NONE, ALU_SRL, 1'b0);
                        else if (f7_alt) alu_ctl = entry(1'b0, 1'b0, IMM_NONE, ALU_SRA, 1'b0);
                    end
                    3'b001: if (f7_base) alu_ctl = entry(1'b0, 1'b0, IMM_NONE, ALU_SLL, 1'b0);
                    3'b010: if (f7_base) alu_ctl = entry(1'b0, 1'b0, IMM_NONE, ALU_SLT, 1'b0);
                    3'b011: if (f7_base) alu_ctl = entry(1'b0, 1'b0, IMM_NONE, ALU_SLTU, 1'b0);
                    3'b100: if (f7_base) alu_ctl = entry(1'b0, 1'b0, IMM_NONE, ALU_XOR, 1'b0);
                    3'b110: if (f7_base) alu_ctl = entry(1'b0, 1'b0, IMM_NONE, ALU_OR, 1'b0);
                    default: begin
                        if (f7_base) alu_ctl = entry(1'b0, 1'b0, IMM_NONE, ALU_AND, 1'b0);
                    end
                endcase
            end
            // MISC_MEM, SYSTEM and unknown opcodes stay NOP
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* hw/branch_resolver.sv */
`timescale 1ns/100ps
`default_nettype none

module branch_resolver (
    input  logic [exe_ctl_pkg::ILEN-1:0] instruction,
    input  logic                         br_eq,
    input  logic                         br_lt,
    output exe_ctl_pkg::br_ctl_t         br_ctl
);
    import exe_ctl_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;

    assign opcode = opcode_e'(instruction[6:0]);
    assign funct3 = instruction[14:12];

    always_comb begin
        br_ctl = '0;
        case (opcode)
            // Jumps always redirect
            OPC_JAL, OPC_JALR: br_ctl.pc_sel = 1'b1;
            OPC_BRANCH: begin
                case (funct3)
                    F3_BEQ: br_ctl.pc_sel = br_eq;
                    F3_BNE: br_ctl.pc_sel = ~br_eq;
                    F3_BLT: br_ctl.pc_sel = br_lt;
                    F3_BGE: br_ctl.pc_sel = ~br_lt;
                    F3_BLTU: begin
                        br_ctl.pc_sel = br_lt;
                        br_ctl.br_un  = 1'b1;
                    end
                    F3_BGEU: begin
                        br_ctl.pc_sel = ~br_lt;
                        br_ctl.br_un  = 1'b1;
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* hw/exe_stage_reg.sv */
`timescale 1ns/100ps
`default_nettype none

module exe_stage_reg (
    input  logic                     clk,
    input  logic                     rst,
    input  exe_ctl_pkg::alu_ctl_t    alu_ctl,
    input  exe_ctl_pkg::br_ctl_t     br_ctl,
    input  exe_ctl_pkg::stage_data_t stage_in,
    output exe_ctl_pkg::alu_ctl_t    ctl_q,
    output exe_ctl_pkg::br_ctl_t     br_q,
    output exe_ctl_pkg::stage_data_t stage_q
);
    import exe_ctl_pkg::*;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ctl_q   <= ALU_CTL_RESET;
            br_q    <= '0;
            stage_q <= '0;
        end else begin
            ctl_q   <= alu_ctl;
            br_q    <= br_ctl;
            stage_q <= stage_in;
        end
    end

    // Resolver output must stay aligned with the instruction it belongs to
    a_br_un_on_branch: assert property (
        @(posedge clk) disable iff (rst)
        br_q.br_un |-> (stage_q.instr[6:0] == OPC_BRANCH)
    ) else $error("br_un set for non-branch instr %h", stage_q.instr);

    a_alu_op_defined: assert property (
        @(posedge clk) disable iff (rst)
        ctl_q.alu_op inside {ALU_AND, ALU_OR, ALU_XOR, ALU_ADD, ALU_SUB, ALU_PASS_B,
                             ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLTU, ALU_SLT}
    ) else $error("undefined alu_op %b", ctl_q.alu_op);

endmodule

`default_nettype wire

/* hw/exe_ctl_top.sv */
`timescale 1ns/100ps
`default_nettype none

module exe_ctl_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [exe_ctl_pkg::ILEN-1:0] instruction,
    input  exe_ctl_pkg::stage_data_t     stage_in,
    input  logic                         br_eq,
    input  logic                         br_lt,
    output exe_ctl_pkg::alu_ctl_t        ctl_q,
    output exe_ctl_pkg::br_ctl_t         br_q,
    output exe_ctl_pkg::stage_data_t     stage_q
);
    import exe_ctl_pkg::*;

    alu_ctl_t    alu_ctl;
    br_ctl_t     br_ctl;
    stage_data_t stage_d;

    // Carried instruction is the one being decoded
    assign stage_d.data_a = stage_in.data_a;
    assign stage_d.data_b = stage_in.data_b;
    assign stage_d.pc     = stage_in.pc;
    assign stage_d.instr  = instruction;

    alu_ctl_decoder alu_dec_i (
        .instruction (instruction),
        .alu_ctl     (alu_ctl)
    );

    branch_resolver br_res_i (
        .instruction (instruction),
        .br_eq       (br_eq),
        .br_lt       (br_lt),
        .br_ctl      (br_ctl)
    );

    exe_stage_reg stage_reg_i (
        .clk      (clk),
        .rst      (rst),
        .alu_ctl  (alu_ctl),
        .br_ctl   (br_ctl),
        .stage_in (stage_d),
        .ctl_q    (ctl_q),
        .br_q     (br_q),
        .stage_q  (stage_q)
    );

endmodule

`default_nettype wire

/* include/exe_ctl_model.svh */
`ifndef EXE_CTL_MODEL_SVH
`define EXE_CTL_MODEL_SVH

// Expects exe_ctl_pkg to be imported by the including module

function automatic alu_ctl_t model_alu_ctl(input logic [31:0] instr);
    alu_ctl_t   c;
    alu_op_e    op;
    logic [2:0] f3;
    logic       is_imm;
    logic       f7_zero;
    logic       f7_alt;
    logic       legal;
    c       = '0;
    f3      = instr[14:12];
    is_imm  = (instr[6:0] == 7'b0010011);
    f7_zero = (instr[31:25] == 7'b0000000);
    f7_alt  = (instr[31:25] == 7'b0100000);
    case (instr[6:0])
        7'b0110111: c = '{1'b0, 1'b1, IMM_U, ALU_PASS_B, 1'b0};
        7'b0010111: c = '{1'b1, 1'b1, IMM_U, ALU_ADD, 1'b0};
        7'b1101111: c = '{1'b1, 1'b1, IMM_J, ALU_ADD, 1'b1};
        7'b1100111: c = '{1'b0, 1'b1, IMM_I, ALU_ADD, 1'b1};
        7'b1100011: if (f3[2:1] != 2'b01) c = '{1'b0, 1'b0, IMM_B, ALU_ADD, 1'b0};
        7'b0000011: if (f3 inside {0, 1, 2, 4, 5}) c = '{1'b0, 1'b1, IMM_I, ALU_ADD, ~f3[2]};
        7'b0100011: if (f3 < 3'd3) c = '{1'b0, 1'b1, IMM_S, ALU_ADD, 1'b1};
        7'b0010011, 7'b0110011: begin
            case (f3)
                3'd0: op = (!is_imm && f7_alt) ? ALU_SUB : ALU_ADD;
                3'd1: op = ALU_SLL;
                3'd2: op = ALU_SLT;
                3'd3: op = ALU_SLTU;
                3'd4: op = ALU_XOR;
                3'd5: op = f7_alt ? ALU_SRA : ALU_SRL;
                3'd6: op = ALU_OR;
                default: op = ALU_AND;
            endcase
            if (is_imm) legal = (f3 == 3'd1) ? f7_zero : (f3 != 3'd5 || f7_zero || f7_alt);
            else        legal = (f3 == 3'd0 || f3 == 3'd5) ? (f7_zero || f7_alt) : f7_zero;
            if (legal) c = '{1'b0, is_imm, is_imm ? IMM_I : IMM_NONE, op,
                             is_imm && (f3 inside {0, 4, 6, 7})};
        end
        default: c = '0;
    endcase
    return c;
endfunction

function automatic br_ctl_t model_br_ctl(input logic [31:0] instr, input logic eq,
                                         input logic lt);
    br_ctl_t b;
    b = '0;
    if (instr[6:0] == 7'b1101111 || instr[6:0] == 7'b1100111) begin
        b.pc_sel = 1'b1;
    end else if (instr[6:0] == 7'b1100011 && instr[14:13] != 2'b01) begin
        // funct3 bit 0 inverts the condition, bit 1 marks unsigned
        b.pc_sel = (instr[14] ? lt : eq) ^ instr[12];
        b.br_un  = instr[13];
    end
    return b;
endfunction

`endif

/* bench/exe_ctl_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module exe_ctl_tb;
    import exe_ctl_pkg::*;

    `include "exe_ctl_model.svh"

    localparam int NUM_CYCLES = 4000;
    localparam int CLK_PERIOD = 10;

    logic            clk;
    logic            rst;
    logic [ILEN-1:0] instruction;
    stage_data_t     stage_in;
    logic            br_eq;
    logic            br_lt;
    alu_ctl_t        ctl_q;
    br_ctl_t         br_q;
    stage_data_t     stage_q;

    logic [31:0] rng_state;
    logic [6:0]  opcode_pool [0:13];
    int          alu_errs;
    int          br_errs;
    int          stage_errs;

    // Inputs driven on the current edge and on the edge before
    logic [ILEN-1:0] cur_instr;
    logic [ILEN-1:0] prev_instr;
    stage_data_t     cur_stage;
    stage_data_t     prev_stage;
    logic            cur_eq;
    logic            cur_lt;
    logic            prev_eq;
    logic            prev_lt;

    exe_ctl_top dut_i (
        .clk         (clk),
        .rst         (rst),
        .instruction (instruction),
        .stage_in    (stage_in),
        .br_eq       (br_eq),
        .br_lt       (br_lt),
        .ctl_q       (ctl_q),
        .br_q        (br_q),
        .stage_q     (stage_q)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic next_rand(output logic [31:0] r);
        rng_state = lcg_next(rng_state);
        r = rng_state;
    endtask

    task automatic make_instr(output logic [ILEN-1:0] instr);
        logic [31:0] r1;
        logic [31:0] r2;
        logic [6:0]  opc;
        logic [6:0]  funct7;
        next_rand(r1);
        next_rand(r2);
        // Two slots in sixteen give a fully random opcode
        if (r1[31:28] < 4'd14) opc = opcode_pool[r1[31:28]];
        else opc = r1[6:0];
        if (r1[27:24] == 4'd0) funct7 = r2[31:25];
        else funct7 = {1'b0, r1[23], 5'b00000};
        instr = {funct7, r2[24:15], r1[22:20], r2[11:7], opc};
        // Exact ECALL and EBREAK now and then
        if (opc == OPC_SYSTEM && r1[19]) instr = r1[18] ? 32'h0010_0073 : 32'h0000_0073;
    endtask

    task automatic drive_random();
        logic [31:0] r;
        make_instr(cur_instr);
        next_rand(r);
        cur_stage.data_a = r;
        next_rand(r);
        cur_stage.data_b = r;
        next_rand(r);
        cur_stage.pc = r;
        // Top level replaces this field with the decoded instruction
        next_rand(r);
        cur_stage.instr = r;
        next_rand(r);
        cur_eq = r[31];
        cur_lt = r[30];
        instruction <= cur_instr;
        stage_in    <= cur_stage;
        br_eq       <= cur_eq;
        br_lt       <= cur_lt;
    endtask

    task automatic check_alu_ctl(input string name, input alu_ctl_t got, input alu_ctl_t exp);
        if (got !== exp) begin
            alu_errs++;
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_br_ctl(input string name, input br_ctl_t got, input br_ctl_t exp);
        if (got !== exp) begin
            br_errs++;
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_stage_data(input string name, input stage_data_t got,
                                    input stage_data_t exp);
        if (got !== exp) begin
            stage_errs++;
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_reset_state();
        check_alu_ctl("ctl_q", ctl_q, ALU_CTL_RESET);
        check_br_ctl("br_q", br_q, '0);
        check_stage_data("stage_q", stage_q, '0);
    endtask

    task automatic check_outputs();
        stage_data_t exp_stage;
        exp_stage       = prev_stage;
        exp_stage.instr = prev_instr;
        check_alu_ctl("ctl_q", ctl_q, model_alu_ctl(prev_instr));
        check_br_ctl("br_q", br_q, model_br_ctl(prev_instr, prev_eq, prev_lt));
        check_stage_data("stage_q", stage_q, exp_stage);
    endtask

    initial begin
        opcode_pool = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH, OPC_BRANCH,
                        OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP_IMM, OPC_OP, OPC_OP,
                        OPC_MISC_MEM, OPC_SYSTEM};
        rng_state   = 32'ha7d1;
        alu_errs    = 0;
        br_errs     = 0;
        stage_errs  = 0;
        clk         = 1'b0;
        rst         = 1'b1;
        instruction = '0;
        stage_in    = '0;
        br_eq       = 1'b0;
        br_lt       = 1'b0;
        cur_instr   = '0;
        prev_instr  = '0;
        cur_stage   = '0;
        prev_stage  = '0;
        cur_eq      = 1'b0;
        cur_lt      = 1'b0;
        prev_eq     = 1'b0;
        prev_lt     = 1'b0;

        repeat (4) begin
            @(posedge clk);
            @(negedge clk);
            check_reset_state();
        end

        // Register still sees rst on the release edge
        @(posedge clk);
        rst <= 1'b0;
        drive_random();
        @(negedge clk);
        check_reset_state();

        for (int i = 0; i < NUM_CYCLES; i++) begin
            @(posedge clk);
            prev_instr = cur_instr;
            prev_stage = cur_stage;
            prev_eq    = cur_eq;
            prev_lt    = cur_lt;
            drive_random();
            @(negedge clk);
            check_outputs();
        end

        $display("Errors: ctl_q %0d, br_q %0d, stage_q %0d", alu_errs, br_errs, stage_errs);
        if (alu_errs + br_errs + stage_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #((NUM_CYCLES + 20) * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d clock cycles", NUM_CYCLES + 20);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+include
hw/exe_ctl_pkg.sv
hw/alu_ctl_decoder.sv
hw/branch_resolver.sv
hw/exe_stage_reg.sv
hw/exe_ctl_top.sv
bench/exe_ctl_tb.sv

/* Makefile */
TOOL      := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := exe_ctl_tb
FLIST     := flist.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qxF '>>> PASS' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
